// ==== src/udp_ins_pkg.sv ====
/*
 * Common types, protocol constants and register map of the UDP framer.
 * Imported by every RTL module that uses one of them.
 */
package udp_ins_pkg;

    typedef logic [31:0] word_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;

    // five IPv4 header words, word 0 is the first on the wire
    typedef logic [0:4][31:0] ip_hdr_t;

    // register map, HI registers hold bits 47:16 and LO registers bits 15:0
    typedef enum logic [3:0] {
        CTRL         = 4'd0,
        MAC_DST_HI   = 4'd1,
        MAC_DST_LO   = 4'd2,
        MAC_SRC_HI   = 4'd3,
        MAC_SRC_LO   = 4'd4,
        IP_SRC       = 4'd5,
        IP_DST       = 4'd6,
        UDP_PORTS    = 4'd7,
        PAYLOAD_SIZE = 4'd9,
        TRN_TYPE     = 4'd10,
        TRN_ID       = 4'd11,
        SKIP_COUNT   = 4'd12
    } csr_addr_t;

    localparam port_t      MAC_TYPE      = 16'h0800;

    localparam logic [3:0] IP_VERSION    = 4'd4;
    localparam logic [3:0] IP_HDR_WORDS  = 4'd5;
    localparam logic [7:0] IP_TOS        = 8'd0;
    localparam logic [7:0] IP_TTL        = 8'd128;
    localparam logic [7:0] IP_PROTO_UDP  = 8'd17;
    // more fragments / don't fragment
    localparam logic [2:0] IP_FLAGS_MF   = 3'd1;
    localparam logic [2:0] IP_FLAGS_DF   = 3'd2;
    localparam port_t      IP_HDR_BYTES  = 16'd20;

    localparam port_t      UDP_HDR_BYTES = 16'd8;
    localparam port_t      UDP_CHECKSUM  = 16'h0000;

    // words put in front of every packet
    localparam int         HDR_WORDS     = 12;
    localparam int         HDR_IDX_W     = 4;

endpackage

// ==== src/net_cfg_if.sv ====
/*
 * Configuration fields and control strobes from the register block
 * to the header datapath and the packet control.
 */
interface net_cfg_if import udp_ins_pkg::*; ();

    mac_addr_t mac_dst;
    mac_addr_t mac_src;
    ip_addr_t  ip_src;
    ip_addr_t  ip_dst;
    port_t     port_src;
    port_t     port_dst;
    word_t     payload_size;
    port_t     trn_type;
    word_t     trn_id;
    logic      id_load;
    logic      go;
    port_t     skip_count;
    logic      skip_load;

    modport csr (
        output mac_dst, mac_src, ip_src, ip_dst, port_src, port_dst,
        output payload_size, trn_type, trn_id, id_load, go, skip_count, skip_load
    );

    modport hdr (
        input mac_dst, mac_src, ip_src, ip_dst, port_src, port_dst,
        input payload_size, trn_type, trn_id, id_load
    );

    modport ctrl (input go, skip_count, skip_load);

endinterface

// ==== src/csr_regs.sv ====
/*
 * Register file of the framer. Byte-enabled writes, combinational readback,
 * and one-cycle load strobes after writes to TRN_ID and SKIP_COUNT.
 */
module csr_regs import udp_ins_pkg::*; (
    input  logic       csi_clock_clk,
    input  logic       csi_clock_reset,
    input  logic       write,
    input  csr_addr_t  address,
    input  logic [3:0] byteenable,
    input  word_t      writedata,
    input  logic       running,
    output word_t      readdata,
    net_cfg_if.csr     cfg
);

    word_t cur;
    word_t nxt;

    // current contents of the addressed register, in its written layout
    always_comb begin
        case (address)
            CTRL:         cur = {30'd0, running, cfg.go};
            MAC_DST_HI:   cur = cfg.mac_dst[47:16];
            MAC_DST_LO:   cur = {16'd0, cfg.mac_dst[15:0]};
            MAC_SRC_HI:   cur = cfg.mac_src[47:16];
            MAC_SRC_LO:   cur = {16'd0, cfg.mac_src[15:0]};
            IP_SRC:       cur = cfg.ip_src;
            IP_DST:       cur = cfg.ip_dst;
            UDP_PORTS:    cur = {cfg.port_src, cfg.port_dst};
            PAYLOAD_SIZE: cur = cfg.payload_size;
            TRN_TYPE:     cur = {16'd0, cfg.trn_type};
            TRN_ID:       cur = cfg.trn_id;
            SKIP_COUNT:   cur = {16'd0, cfg.skip_count};
            default:      cur = '0;
        endcase
    end

    // bytes without their enable keep the old value
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            nxt[8*i +: 8] = byteenable[i] ? writedata[8*i +: 8] : cur[8*i +: 8];
        end
    end

    assign readdata = cur;

    always_ff @(posedge csi_clock_clk) begin
        if (csi_clock_reset) begin
            cfg.go           <= 1'b0;
            cfg.id_load      <= 1'b0;
            cfg.skip_load    <= 1'b0;
            cfg.mac_dst      <= '0;
            cfg.mac_src      <= '0;
            cfg.ip_src       <= '0;
            cfg.ip_dst       <= '0;
            cfg.port_src     <= '0;
            cfg.port_dst     <= '0;
            cfg.payload_size <= '0;
            cfg.trn_type     <= '0;
            cfg.trn_id       <= '0;
            cfg.skip_count   <= '0;
        end else begin
            cfg.id_load   <= write && (address == TRN_ID);
            cfg.skip_load <= write && (address == SKIP_COUNT);
            if (write) begin
                case (address)
                    CTRL:         cfg.go                     <= nxt[0];
                    MAC_DST_HI:   cfg.mac_dst[47:16]         <= nxt;
                    MAC_DST_LO:   cfg.mac_dst[15:0]          <= nxt[15:0];
                    MAC_SRC_HI:   cfg.mac_src[47:16]         <= nxt;
                    MAC_SRC_LO:   cfg.mac_src[15:0]          <= nxt[15:0];
                    IP_SRC:       cfg.ip_src                 <= nxt;
                    IP_DST:       cfg.ip_dst                 <= nxt;
                    UDP_PORTS:    {cfg.port_src, cfg.port_dst} <= nxt;
                    PAYLOAD_SIZE: cfg.payload_size           <= nxt;
                    TRN_TYPE:     cfg.trn_type               <= nxt[15:0];
                    TRN_ID:       cfg.trn_id                 <= nxt;
                    SKIP_COUNT:   cfg.skip_count             <= nxt[15:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== src/ip_checksum.sv ====
/*
 * IPv4 header checksum, a 5-stage adder tree over the header half-words.
 * The result follows its inputs by 5 clocks.
 */
module ip_checksum import udp_ins_pkg::*; (
    input  logic    csi_clock_clk,
    input  logic    csi_clock_reset,
    input  ip_hdr_t ip_words,
    output port_t   checksum
);

    logic [16:0] sum_w0, sum_w1, sum_w3, sum_w4;
    port_t       sum_w2;
    logic [17:0] sum_a, sum_b;
    logic [18:0] sum_c;
    logic [19:0] sum_d;
    logic [16:0] sum_e;
    port_t       folded;

    always_ff @(posedge csi_clock_clk) begin
        if (csi_clock_reset) begin
            {sum_w0, sum_w1, sum_w2, sum_w3, sum_w4} <= '0;
            {sum_a, sum_b, sum_c, sum_d, sum_e} <= '0;
        end else begin
            // word 2 low half is the checksum itself
            sum_w0 <= ip_words[0][31:16] + ip_words[0][15:0];
            sum_w1 <= ip_words[1][31:16] + ip_words[1][15:0];
            sum_w2 <= ip_words[2][31:16];
            sum_w3 <= ip_words[3][31:16] + ip_words[3][15:0];
            sum_w4 <= ip_words[4][31:16] + ip_words[4][15:0];
            sum_a  <= sum_w0 + sum_w1;
            sum_b  <= sum_w3 + sum_w4;
            sum_c  <= sum_a + sum_b;
            sum_d  <= sum_c + sum_w2;
            // first carry fold
            sum_e  <= sum_d[19:16] + sum_d[15:0];
        end
    end

    // second fold cannot carry out again
    assign folded   = sum_e[15:0] + sum_e[16];
    assign checksum = ~folded;

endmodule

// ==== src/header_builder.sv ====
/*
 * Builds the 12 header words (MAC, IPv4, UDP, transaction type, counter).
 * hdr_word follows hdr_index combinationally; counters step on pkt_done.
 */
module header_builder import udp_ins_pkg::*; #(
    parameter int unsigned mtu = 1500
) (
    input  logic                 csi_clock_clk,
    input  logic                 csi_clock_reset,
    net_cfg_if.hdr               cfg,
    input  logic [HDR_IDX_W-1:0] hdr_index,
    input  logic                 pkt_done,
    output word_t                hdr_word
);

    port_t       udp_len;
    logic [16:0] ip_len_raw;
    logic        clamped;
    port_t       ip_total;
    port_t       ip_id;
    port_t       checksum;
    word_t       pkt_cnt;
    ip_hdr_t     ip_words;
    word_t       udp_w0;
    word_t       udp_w1;

    assign udp_len    = UDP_HDR_BYTES + cfg.payload_size[15:0];
    assign ip_len_raw = IP_HDR_BYTES + udp_len;
    assign clamped    = ip_len_raw > 17'(mtu);
    assign ip_total   = clamped ? port_t'(mtu) : ip_len_raw[15:0];

    assign ip_words[0] = {IP_VERSION, IP_HDR_WORDS, IP_TOS, ip_total};
    assign ip_words[1] = {ip_id, clamped ? IP_FLAGS_MF : IP_FLAGS_DF, 13'd0};
    assign ip_words[2] = {IP_TTL, IP_PROTO_UDP, checksum};
    assign ip_words[3] = cfg.ip_src;
    assign ip_words[4] = cfg.ip_dst;
    assign udp_w0      = {cfg.port_src, cfg.port_dst};
    assign udp_w1      = {udp_len, UDP_CHECKSUM};

    ip_checksum u_checksum (
        .csi_clock_clk   (csi_clock_clk),
        .csi_clock_reset (csi_clock_reset),
        .ip_words        (ip_words),
        .checksum        (checksum)
    );

    always_ff @(posedge csi_clock_clk) begin
        if (csi_clock_reset) begin
            pkt_cnt <= '0;
            ip_id   <= '0;
        end else begin
            if (cfg.id_load) begin
                pkt_cnt <= cfg.trn_id;
            end else if (pkt_done) begin
                pkt_cnt <= pkt_cnt + 1'b1;
            end
            if (pkt_done) begin
                ip_id <= ip_id + 1'b1;
            end
        end
    end

    // after the MAC type everything sits at a half-word offset
    always_comb begin
        case (hdr_index)
            4'd0:    hdr_word = cfg.mac_dst[47:16];
            4'd1:    hdr_word = {cfg.mac_dst[15:0], cfg.mac_src[47:32]};
            4'd2:    hdr_word = cfg.mac_src[31:0];
            4'd3:    hdr_word = {MAC_TYPE, ip_words[0][31:16]};
            4'd4:    hdr_word = {ip_words[0][15:0], ip_words[1][31:16]};
            4'd5:    hdr_word = {ip_words[1][15:0], ip_words[2][31:16]};
            4'd6:    hdr_word = {ip_words[2][15:0], ip_words[3][31:16]};
            4'd7:    hdr_word = {ip_words[3][15:0], ip_words[4][31:16]};
            4'd8:    hdr_word = {ip_words[4][15:0], udp_w0[31:16]};
            4'd9:    hdr_word = {udp_w0[15:0], udp_w1[31:16]};
            4'd10:   hdr_word = {udp_w1[15:0], cfg.trn_type};
            4'd11:   hdr_word = {pkt_cnt[7:0], pkt_cnt[15:8], pkt_cnt[23:16], pkt_cnt[31:24]};
            default: hdr_word = '0;
        endcase
    end

endmodule

// ==== src/inserter_ctrl.sv ====
/*
 * Packet FSM of the framer. Sends the header, then the held first word,
 * then the rest of the payload. Skipped packets are consumed without output.
 */
module inserter_ctrl import udp_ins_pkg::*; (
    input  logic                 csi_clock_clk,
    input  logic                 csi_clock_reset,
    net_cfg_if.ctrl              cfg,
    input  logic                 src_ready,
    input  word_t                snk_data,
    input  logic                 snk_valid,
    input  logic                 snk_sof,
    input  logic                 snk_eof,
    input  logic [1:0]           snk_empty,
    input  word_t                hdr_word,
    output logic                 snk_ready,
    output word_t                src_data,
    output logic                 src_valid,
    output logic                 src_sof,
    output logic                 src_eof,
    output logic [1:0]           src_empty,
    output logic [HDR_IDX_W-1:0] hdr_index,
    output logic                 pkt_done,
    output logic                 running
);

    typedef enum logic [2:0] {idle, insert, first_payload, payload, drop} state_t;

    state_t     state;
    port_t      skip_remain;
    word_t      hold_data;
    logic       hold_eof;
    logic [1:0] hold_empty;
    logic       sink_accept;
    logic       last_index;

    // sink stalls while the header and the held word go out
    assign snk_ready   = src_ready && (state != insert) && (state != first_payload);
    assign sink_accept = snk_valid && snk_ready;
    assign running     = (state != idle);
    assign last_index  = (hdr_index == HDR_IDX_W'(HDR_WORDS - 1));

    always_comb begin
        case (state)
            // one-word packet dropped straight from idle
            idle:          pkt_done = sink_accept && snk_sof && snk_eof && cfg.go
                                      && (skip_remain != '0);
            first_payload: pkt_done = src_ready && hold_eof;
            payload, drop: pkt_done = sink_accept && snk_eof;
            default:       pkt_done = 1'b0;
        endcase
    end

    always_ff @(posedge csi_clock_clk) begin
        if (csi_clock_reset) begin
            state       <= idle;
            hdr_index   <= '0;
            skip_remain <= '0;
            src_valid   <= 1'b0;
            src_sof     <= 1'b0;
            src_eof     <= 1'b0;
        end else begin
            if (cfg.skip_load) begin
                skip_remain <= cfg.skip_count;
            end else if (pkt_done && (state == idle || state == drop)) begin
                skip_remain <= skip_remain - 1'b1;
            end
            if (src_ready) begin
                case (state)
                    idle: begin
                        src_valid <= 1'b0;
                        src_sof   <= 1'b0;
                        src_eof   <= 1'b0;
                        if (sink_accept && snk_sof && cfg.go) begin
                            if (skip_remain == '0) begin
                                state <= insert;
                            end else if (!snk_eof) begin
                                state <= drop;
                            end
                        end
                    end
                    insert: begin
                        src_valid <= 1'b1;
                        src_sof   <= (hdr_index == '0);
                        src_eof   <= 1'b0;
                        hdr_index <= last_index ? '0 : hdr_index + 1'b1;
                        if (last_index) begin
                            state <= first_payload;
                        end
                    end
                    first_payload: begin
                        src_sof <= 1'b0;
                        src_eof <= hold_eof;
                        state   <= hold_eof ? idle : payload;
                    end
                    payload: begin
                        src_valid <= snk_valid;
                        src_eof   <= snk_valid && snk_eof;
                        if (snk_valid && snk_eof) begin
                            state <= idle;
                        end
                    end
                    default: begin
                        src_valid <= 1'b0;
                        if (snk_valid && snk_eof) begin
                            state <= idle;
                        end
                    end
                endcase
            end
        end
    end

    // output word and the first payload word held during the header
    always_ff @(posedge csi_clock_clk) begin
        if (src_ready) begin
            case (state)
                insert: begin
                    src_data  <= hdr_word;
                    src_empty <= 2'd0;
                end
                first_payload: begin
                    src_data  <= hold_data;
                    src_empty <= hold_empty;
                end
                default: begin
                    src_data  <= snk_data;
                    src_empty <= snk_empty;
                end
            endcase
            if (state == idle) begin
                hold_data  <= snk_data;
                hold_eof   <= snk_eof;
                hold_empty <= snk_empty;
            end
        end
    end

endmodule

// ==== src/udp_payload_inserter.sv ====
/*
 * UDP framer top level. Register port, sink and source streams as plain ports;
 * register block, header datapath and packet FSM are connected inside.
 */
module udp_payload_inserter import udp_ins_pkg::*; #(
    parameter int unsigned MTU = 1500
) (
    input  logic       csi_clock_clk,
    input  logic       csi_clock_reset,
    input  logic       write,
    input  csr_addr_t  address,
    input  logic [3:0] byteenable,
    input  word_t      writedata,
    output word_t      readdata,
    input  logic       src_ready,
    output word_t      src_data,
    output logic       src_valid,
    output logic       src_sof,
    output logic       src_eof,
    output logic [1:0] src_empty,
    output logic       snk_ready,
    input  word_t      snk_data,
    input  logic       snk_valid,
    input  logic       snk_sof,
    input  logic       snk_eof,
    input  logic [1:0] snk_empty
);

    logic                 running;
    logic                 pkt_done;
    logic [HDR_IDX_W-1:0] hdr_index;
    word_t                hdr_word;

    net_cfg_if cfg_if ();

    csr_regs u_csr (
        .csi_clock_clk   (csi_clock_clk),
        .csi_clock_reset (csi_clock_reset),
        .write           (write),
        .address         (address),
        .byteenable      (byteenable),
        .writedata       (writedata),
        .running         (running),
        .readdata        (readdata),
        .cfg             (cfg_if.csr)
    );

    header_builder #(.mtu(MTU)) u_header (
        .csi_clock_clk   (csi_clock_clk),
        .csi_clock_reset (csi_clock_reset),
        .cfg             (cfg_if.hdr),
        .hdr_index       (hdr_index),
        .pkt_done        (pkt_done),
        .hdr_word        (hdr_word)
    );

    inserter_ctrl u_ctrl (
        .csi_clock_clk   (csi_clock_clk),
        .csi_clock_reset (csi_clock_reset),
        .cfg             (cfg_if.ctrl),
        .src_ready       (src_ready),
        .snk_data        (snk_data),
        .snk_valid       (snk_valid),
        .snk_sof         (snk_sof),
        .snk_eof         (snk_eof),
        .snk_empty       (snk_empty),
        .hdr_word        (hdr_word),
        .snk_ready       (snk_ready),
        .src_data        (src_data),
        .src_valid       (src_valid),
        .src_sof         (src_sof),
        .src_eof         (src_eof),
        .src_empty       (src_empty),
        .hdr_index       (hdr_index),
        .pkt_done        (pkt_done),
        .running         (running)
    );

endmodule

// ==== sim/tb_ref_model.svh ====
/*
 * Reference model of the framer header, built from the protocol rules as one
 * 48-byte stream. Included into the testbench module.
 */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct {
    mac_addr_t mac_dst;
    mac_addr_t mac_src;
    ip_addr_t  ip_src;
    ip_addr_t  ip_dst;
    port_t     port_src;
    port_t     port_dst;
    word_t     payload_size;
    port_t     trn_type;
} net_cfg_t;

// ones'-complement sum of the ten half-words, with the checksum field zero
function automatic port_t ref_checksum(ip_hdr_t ip);
    logic [31:0] sum;
    sum = 32'd0;
    for (int i = 0; i < 5; i++) begin
        sum = sum + 32'(ip[i][31:16]) + 32'(ip[i][15:0]);
    end
    while (sum[31:16] != 16'd0) begin
        sum = 32'(sum[31:16]) + 32'(sum[15:0]);
    end
    return ~sum[15:0];
endfunction

function automatic word_t ref_header_word(net_cfg_t c, port_t ip_id, word_t cnt,
                                          int mtu_bytes, int idx);
    port_t        udp_len;
    port_t        ip_len;
    int           total;
    logic [2:0]   flags;
    ip_hdr_t      ip;
    logic [383:0] stream;
    udp_len = 16'd8 + c.payload_size[15:0];
    total   = 20 + int'(udp_len);
    // longer than one frame, so more fragments follow
    if (total > mtu_bytes) begin
        ip_len = port_t'(mtu_bytes);
        flags  = 3'd1;
    end else begin
        ip_len = port_t'(total);
        flags  = 3'd2;
    end
    ip[0] = {4'd4, 4'd5, 8'd0, ip_len};
    ip[1] = {ip_id, flags, 13'd0};
    ip[2] = {8'd128, 8'd17, 16'd0};
    ip[3] = c.ip_src;
    ip[4] = c.ip_dst;
    ip[2][15:0] = ref_checksum(ip);
    // counter goes out least significant byte first
    stream = {c.mac_dst, c.mac_src, 16'h0800, ip, c.port_src, c.port_dst, udp_len,
              16'h0000, c.trn_type, cnt[7:0], cnt[15:8], cnt[23:16], cnt[31:24]};
    return stream[383 - 32 * idx -: 32];
endfunction

`endif

// ==== sim/tb_udp_inserter.sv ====
/*
 * Testbench of the UDP framer. Programs the registers, sends random packets
 * under random output back-pressure and checks every output word against the
 * reference header model. Built and run by run_sim.sh.
 */
module tb_udp_inserter import udp_ins_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MTU       = 1500;
    localparam int MAX_WORDS = 24;
    // 11 packets over all tests, plus register accesses and idle gaps
    localparam int TEST_WORDS = 11 * (MAX_WORDS + HDR_WORDS) + 200;

    `include "tb_ref_model.svh"

    typedef struct {
        word_t      data;
        logic       sof;
        logic       eof;
        logic [1:0] empty;
    } exp_word_t;

    logic       csi_clock_clk;
    logic       csi_clock_reset;
    logic       write;
    csr_addr_t  address;
    logic [3:0] byteenable;
    word_t      writedata, readdata, src_data, snk_data;
    logic       src_ready, src_valid, src_sof, src_eof, snk_ready;
    logic       snk_valid, snk_sof, snk_eof, gaps_on;
    logic [1:0] src_empty, snk_empty;

    exp_word_t exp_q[$];
    net_cfg_t  cfg;
    port_t     exp_id;
    word_t     exp_cnt;
    int        errors = 0;
    int        checks = 0;
    int        tests = 0;
    int        failed_tests = 0;

    udp_payload_inserter #(.MTU(MTU)) DUT (.*);

    initial begin
        csi_clock_clk = 1'b0;
        forever #5 csi_clock_clk = ~csi_clock_clk;
    end

    // output back-pressure, random gaps while gaps_on is set
    initial begin
        src_ready = 1'b1;
        forever begin
            @(posedge csi_clock_clk);
            #1;
            src_ready = gaps_on ? (($urandom % 4) != 0) : 1'b1;
        end
    end

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flags(logic sof, logic eof, logic [1:0] empty,
                               logic exp_sof, logic exp_eof, logic [1:0] exp_empty);
        checks++;
        if ({sof, eof, empty} !== {exp_sof, exp_eof, exp_empty}) begin
            errors++;
            $display("Fail src_sof/src_eof/src_empty: got %h/%h/%h, expected %h/%h/%h",
                     sof, eof, empty, exp_sof, exp_eof, exp_empty);
        end
    endtask

    // a word moves on the next edge when valid and ready are both high
    always @(negedge csi_clock_clk) begin
        exp_word_t e;
        if (!csi_clock_reset && src_valid && src_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("output word %h arrived while no word was expected", src_data);
            end else begin
                e = exp_q.pop_front();
                check_word("src_data", src_data, e.data);
                check_flags(src_sof, src_eof, src_empty, e.sof, e.eof, e.empty);
            end
        end
    end

    initial begin
        repeat (200 * TEST_WORDS) @(posedge csi_clock_clk);
        $display("watchdog: run did not finish within %0d cycles", 200 * TEST_WORDS);
        $display("Some tests failed");
        $finish;
    end

    task automatic wait_cycles(int n);
        repeat (n) @(posedge csi_clock_clk);
        #1;
    endtask

    task automatic reg_write(csr_addr_t a, word_t d, logic [3:0] be);
        address    = a;
        writedata  = d;
        byteenable = be;
        write      = 1'b1;
        wait_cycles(1);
        write = 1'b0;
    endtask

    task automatic reg_read(csr_addr_t a, output word_t v);
        address = a;
        @(negedge csi_clock_clk);
        v = readdata;
        wait_cycles(1);
    endtask

    task automatic apply_config();
        reg_write(MAC_DST_HI, cfg.mac_dst[47:16], 4'hf);
        reg_write(MAC_DST_LO, {16'd0, cfg.mac_dst[15:0]}, 4'hf);
        reg_write(MAC_SRC_HI, cfg.mac_src[47:16], 4'hf);
        reg_write(MAC_SRC_LO, {16'd0, cfg.mac_src[15:0]}, 4'hf);
        reg_write(IP_SRC, cfg.ip_src, 4'hf);
        reg_write(IP_DST, cfg.ip_dst, 4'hf);
        reg_write(UDP_PORTS, {cfg.port_src, cfg.port_dst}, 4'hf);
        reg_write(PAYLOAD_SIZE, cfg.payload_size, 4'hf);
        reg_write(TRN_TYPE, {16'd0, cfg.trn_type}, 4'hf);
        // checksum pipeline follows the new fields
        wait_cycles(8);
    endtask

    task automatic load_trn_id(word_t id);
        reg_write(TRN_ID, id, 4'hf);
        exp_cnt = id;
        wait_cycles(8);
    endtask

    task automatic send_word(word_t d, logic sof, logic eof, logic [1:0] empty);
        snk_data  = d;
        snk_sof   = sof;
        snk_eof   = eof;
        snk_empty = empty;
        snk_valid = 1'b1;
        @(negedge csi_clock_clk);
        while (!snk_ready) begin
            @(negedge csi_clock_clk);
        end
        wait_cycles(1);
        snk_valid = 1'b0;
        snk_sof   = 1'b0;
        snk_eof   = 1'b0;
        snk_empty = 2'd0;
    endtask

    // framed packets are expected on the output, counted ones step the counters
    task automatic send_packet(logic framed, logic counted);
        word_t      pay[$];
        exp_word_t  e;
        int         n;
        logic [1:0] last_empty;
        n = int'($urandom_range(MAX_WORDS, 2));
        last_empty = 2'($urandom);
        for (int i = 0; i < n; i++) begin
            pay.push_back($urandom);
        end
        for (int i = 0; framed && i < HDR_WORDS + n; i++) begin
            e.sof   = (i == 0);
            e.eof   = (i == HDR_WORDS + n - 1);
            e.empty = e.eof ? last_empty : 2'd0;
            e.data  = (i < HDR_WORDS) ? ref_header_word(cfg, exp_id, exp_cnt, MTU, i)
                                      : pay[i - HDR_WORDS];
            exp_q.push_back(e);
        end
        for (int i = 0; i < n; i++) begin
            send_word(pay[i], i == 0, i == n - 1, (i == n - 1) ? last_empty : 2'd0);
        end
        if (counted) begin
            exp_id++;
            exp_cnt++;
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge csi_clock_clk);
        end
        wait_cycles(20);
    endtask

    task automatic end_test(string name, int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
        end
    endtask

    initial begin
        int    e0;
        word_t rd;
        void'($urandom(32'h02d7c90a));
        csi_clock_reset = 1'b1;
        write      = 1'b0;
        address    = CTRL;
        byteenable = 4'h0;
        writedata  = '0;
        snk_data   = '0;
        snk_valid  = 1'b0;
        snk_sof    = 1'b0;
        snk_eof    = 1'b0;
        snk_empty  = 2'd0;
        gaps_on    = 1'b0;
        exp_id     = '0;
        exp_cnt    = '0;
        repeat (16) @(posedge csi_clock_clk);
        #1;
        csi_clock_reset = 1'b0;

        e0 = errors;
        reg_write(IP_SRC, 32'h1122_3344, 4'hf);
        reg_write(IP_SRC, 32'haabb_ccdd, 4'b0101);
        reg_read(IP_SRC, rd);
        check_word("readdata IP_SRC", rd, 32'h11bb_33dd);
        reg_write(MAC_DST_LO, 32'hffff_5678, 4'b1110);
        reg_read(MAC_DST_LO, rd);
        check_word("readdata MAC_DST_LO", rd, 32'h0000_5600);
        reg_write(UDP_PORTS, 32'h1234_abcd, 4'b1100);
        reg_read(UDP_PORTS, rd);
        check_word("readdata UDP_PORTS", rd, 32'h1234_0000);
        // running is read-only and low while idle
        reg_write(CTRL, 32'hffff_ffff, 4'h1);
        reg_read(CTRL, rd);
        check_word("readdata CTRL", rd, 32'h0000_0001);
        reg_read(csr_addr_t'(4'd8), rd);
        check_word("readdata unmapped", rd, 32'h0000_0000);
        end_test("register map", e0);

        cfg.mac_dst      = 48'h0011_2233_4455;
        cfg.mac_src      = 48'h6677_8899_aabb;
        cfg.ip_src       = 32'hc0a8_0001;
        cfg.ip_dst       = 32'hc0a8_0064;
        cfg.port_src     = 16'd4000;
        cfg.port_dst     = 16'd5001;
        cfg.payload_size = 32'd256;
        cfg.trn_type     = 16'h00a5;
        apply_config();
        load_trn_id(32'h0000_0100);
        gaps_on = 1'b1;
        e0 = errors;
        send_packet(1'b1, 1'b1);
        drain();
        end_test("single packet", e0);

        e0 = errors;
        cfg.payload_size = 32'd2000;
        apply_config();
        send_packet(1'b1, 1'b1);
        drain();
        end_test("mtu clamp", e0);

        e0 = errors;
        cfg.payload_size = 32'd256;
        apply_config();
        repeat (3) send_packet(1'b1, 1'b1);
        load_trn_id(32'hcafe_0001);
        send_packet(1'b1, 1'b1);
        drain();
        end_test("counters", e0);

        e0 = errors;
        reg_write(SKIP_COUNT, 32'd2, 4'hf);
        wait_cycles(8);
        repeat (2) send_packet(1'b0, 1'b1);
        send_packet(1'b1, 1'b1);
        drain();
        end_test("skip count", e0);

        e0 = errors;
        reg_write(CTRL, 32'd0, 4'hf);
        wait_cycles(8);
        send_packet(1'b0, 1'b0);
        drain();
        reg_write(CTRL, 32'd1, 4'hf);
        wait_cycles(8);
        send_packet(1'b1, 1'b1);
        drain();
        end_test("go clear", e0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+sim
src/udp_ins_pkg.sv
src/net_cfg_if.sv
src/csr_regs.sv
src/ip_checksum.sv
src/header_builder.sv
src/inserter_ctrl.sv
src/udp_payload_inserter.sv
sim/tb_udp_inserter.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_udp_inserter -Mdir obj_dir \
    && ./obj_dir/Vtb_udp_inserter | tee sim.log \
    && grep -qx "All tests passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
